/* rtl/rbm_macros.svh */
`ifndef RBM_MACROS_SVH
`define RBM_MACROS_SVH

// Network dimensions
`define RBM_INPUT_DIM   15
`define RBM_HIDDEN_DIM  5
`define RBM_OUTPUT_DIM  2

// Feature and weight widths, both signed
`define RBM_DATA_W      12
`define RBM_WEIGHT_W    8

// Hidden probability, 256 stands for 1.0
`define RBM_PROB_W      8

`define RBM_ACC_W       24
`define RBM_SCORE_W     20

`endif

/* rtl/rbm_pkg.sv */
`default_nettype none

`include "rbm_macros.svh"

package rbm_pkg;

  typedef struct packed {
    logic signed [`RBM_DATA_W-1:0] feature;
    logic                          last;
  } feature_beat_t;

  // Feature with its position in the vector
  typedef struct packed {
    logic signed [`RBM_DATA_W-1:0] feature;
    logic [3:0]                    index;
    logic                          last;
  } feature_bcast_t;

  typedef struct packed {
    logic signed [`RBM_SCORE_W-1:0] score1;
    logic signed [`RBM_SCORE_W-1:0] score0;
    logic                           class_id;
  } rbm_result_t;

  typedef enum logic [1:0] {
    CL_IDLE,
    CL_ACCUMULATE,
    CL_HOLD
  } class_state_t;

  // Input i to hidden unit j, range -15 to 15
  function automatic logic signed [`RBM_WEIGHT_W-1:0] hidden_weight(input int i, input int j);
    return `RBM_WEIGHT_W'(((7 * i + 13 * j) % 31) - 15);
  endfunction

  function automatic logic signed [`RBM_ACC_W-1:0] hidden_bias(input int j);
    return `RBM_ACC_W'(64 * j - 128);
  endfunction

  // Hidden unit j to output k, range -8 to 8
  function automatic logic signed [`RBM_WEIGHT_W-1:0] class_weight(input int j, input int k);
    return `RBM_WEIGHT_W'(((5 * j + 11 * k) % 17) - 8);
  endfunction

  function automatic logic signed [`RBM_SCORE_W-1:0] class_bias(input int k);
    return `RBM_SCORE_W'(512 * k - 256);
  endfunction

endpackage

`default_nettype wire

/* rtl/feature_sequencer.sv */
`default_nettype none

module feature_sequencer import rbm_pkg::*; (
  input  logic           finish,
  input  logic           rst_n,

  input  feature_beat_t  in_beat,
  input  logic           in_valid,
  output logic           in_ready,

  output feature_bcast_t bcast,
  output logic           bcast_valid,
  input  logic           units_ready
);

  logic [3:0] index_q;
  logic       xfer;

  // Stream passes straight through, only the index is added
  assign in_ready    = units_ready;
  assign bcast_valid = in_valid;
  assign xfer        = in_valid & units_ready;

  always_comb begin
    bcast.feature = in_beat.feature;
    bcast.index   = index_q;
    bcast.last    = in_beat.last;
  end

  always_ff @(posedge finish or negedge rst_n) begin
    if (!rst_n) begin
      index_q <= '0;
    end else if (xfer) begin
      // Next vector starts at feature 0
      if (in_beat.last) begin
        index_q <= '0;
      end else begin
        index_q <= index_q + 4'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/hidden_unit.sv */
`default_nettype none

`include "rbm_macros.svh"

module hidden_unit import rbm_pkg::*; #(
  parameter int UNIT_INDEX = 0
) (
  input  logic                   finish,
  input  logic                   rst_n,

  input  feature_bcast_t         bcast,
  input  logic                   bcast_valid,
  output logic                   ready,

  output logic [`RBM_PROB_W-1:0] prob,
  output logic                   prob_valid,
  input  logic                   take
);

  // Covers every value of the 4-bit index
  localparam int ROM_DEPTH = 16;
  localparam logic signed [`RBM_ACC_W-1:0] BIAS    = hidden_bias(UNIT_INDEX);
  localparam logic signed [`RBM_ACC_W-1:0] SIG_MID = 128;
  localparam logic signed [`RBM_ACC_W-1:0] PROB_MAX = (1 << `RBM_PROB_W) - 1;

  logic signed [`RBM_WEIGHT_W-1:0] weight_rom [ROM_DEPTH];
  logic signed [`RBM_ACC_W-1:0]    acc;
  logic signed [`RBM_ACC_W-1:0]    product;
  logic signed [`RBM_ACC_W-1:0]    acc_next;
  logic signed [`RBM_ACC_W-1:0]    z;
  logic signed [`RBM_ACC_W-1:0]    sig_lin;
  logic [`RBM_PROB_W-1:0]          sig_clamped;
  logic                            accept;

  // Weight column of this unit
  for (genvar i = 0; i < ROM_DEPTH; i++) begin : g_rom
    if (i < `RBM_INPUT_DIM) begin : g_used
      assign weight_rom[i] = hidden_weight(i, UNIT_INDEX);
    end else begin : g_unused
      assign weight_rom[i] = '0;
    end
  end

  // Free again in the cycle the class layer copies prob
  assign ready  = ~prob_valid | take;
  assign accept = bcast_valid & ready;

  assign product  = $signed(bcast.feature) * weight_rom[bcast.index];
  assign acc_next = acc + product;

  // Piecewise-linear sigmoid around one half
  assign z       = acc_next >>> 8;
  assign sig_lin = SIG_MID + (z >>> 2);

  always_comb begin
    if (sig_lin < 0) begin
      sig_clamped = '0;
    end else if (sig_lin > PROB_MAX) begin
      sig_clamped = '1;
    end else begin
      sig_clamped = sig_lin[`RBM_PROB_W-1:0];
    end
  end

  always_ff @(posedge finish or negedge rst_n) begin
    if (!rst_n) begin
      acc        <= BIAS;
      prob_valid <= 1'b0;
    end else begin
      if (accept) begin
        acc <= bcast.last ? BIAS : acc_next;
      end
      if (accept && bcast.last) begin
        prob_valid <= 1'b1;
      end else if (take) begin
        prob_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge finish) begin
    if (accept && bcast.last) begin
      prob <= sig_clamped;
    end
  end

endmodule

`default_nettype wire

/* rtl/class_layer.sv */
`default_nettype none

`include "rbm_macros.svh"

module class_layer import rbm_pkg::*; (
  input  logic                                         finish,
  input  logic                                         rst_n,

  input  logic [`RBM_HIDDEN_DIM-1:0][`RBM_PROB_W-1:0] probs,
  input  logic [`RBM_HIDDEN_DIM-1:0]                   probs_valid,
  output logic                                         take,

  output rbm_result_t                                  out_result,
  output logic                                         out_valid,
  input  logic                                         out_ready
);

  localparam int CNT_W = $clog2(`RBM_HIDDEN_DIM);
  localparam logic [CNT_W-1:0] LAST_UNIT = CNT_W'(`RBM_HIDDEN_DIM - 1);

  class_state_t                    state;
  logic [CNT_W-1:0]                unit_cnt;
  logic [`RBM_PROB_W-1:0]          prob_q [`RBM_HIDDEN_DIM];
  logic signed [`RBM_WEIGHT_W-1:0] weight_rom [`RBM_OUTPUT_DIM][`RBM_HIDDEN_DIM];
  logic signed [`RBM_SCORE_W-1:0]  score_q [`RBM_OUTPUT_DIM];
  logic signed [`RBM_PROB_W:0]     prob_ext;

  for (genvar k = 0; k < `RBM_OUTPUT_DIM; k++) begin : g_out
    for (genvar j = 0; j < `RBM_HIDDEN_DIM; j++) begin : g_hid
      assign weight_rom[k][j] = class_weight(j, k);
    end
  end

  // All units done and nothing in flight here
  assign take      = (state == CL_IDLE) & (&probs_valid);
  assign out_valid = (state == CL_HOLD);

  // Probabilities are unsigned
  assign prob_ext = $signed({1'b0, prob_q[unit_cnt]});

  always_comb begin
    out_result.score0   = score_q[0];
    out_result.score1   = score_q[1];
    out_result.class_id = (score_q[1] > score_q[0]);
  end

  always_ff @(posedge finish or negedge rst_n) begin
    if (!rst_n) begin
      state    <= CL_IDLE;
      unit_cnt <= '0;
    end else begin
      case (state)
        CL_IDLE: begin
          if (take) begin
            state    <= CL_ACCUMULATE;
            unit_cnt <= '0;
          end
        end
        CL_ACCUMULATE: begin
          unit_cnt <= unit_cnt + 1'b1;
          if (unit_cnt == LAST_UNIT) begin
            state <= CL_HOLD;
          end
        end
        CL_HOLD: begin
          if (out_ready) begin
            state <= CL_IDLE;
          end
        end
        default: state <= CL_IDLE;
      endcase
    end
  end

  // One hidden unit per cycle into both scores
  always_ff @(posedge finish) begin
    if (take) begin
      for (int j = 0; j < `RBM_HIDDEN_DIM; j++) begin
        prob_q[j] <= probs[j];
      end
      for (int k = 0; k < `RBM_OUTPUT_DIM; k++) begin
        score_q[k] <= class_bias(k);
      end
    end else if (state == CL_ACCUMULATE) begin
      for (int k = 0; k < `RBM_OUTPUT_DIM; k++) begin
        score_q[k] <= score_q[k] + prob_ext * weight_rom[k][unit_cnt];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/rbm_top.sv */
`default_nettype none

`include "rbm_macros.svh"

module rbm_top import rbm_pkg::*; (
  input  logic          finish,
  input  logic          rst_n,

  input  feature_beat_t in_beat,
  input  logic          in_valid,
  output logic          in_ready,

  output rbm_result_t   out_result,
  output logic          out_valid,
  input  logic          out_ready
);

  feature_bcast_t                              bcast;
  logic                                        bcast_valid;
  logic                                        units_ready;
  logic [`RBM_HIDDEN_DIM-1:0]                  unit_ready;
  logic [`RBM_HIDDEN_DIM-1:0][`RBM_PROB_W-1:0] probs;
  logic [`RBM_HIDDEN_DIM-1:0]                  probs_valid;
  logic                                        take;

  // Every unit must take the same beat
  assign units_ready = &unit_ready;

  feature_sequencer u_seq (
    .finish      (finish),
    .rst_n       (rst_n),
    .in_beat     (in_beat),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .bcast       (bcast),
    .bcast_valid (bcast_valid),
    .units_ready (units_ready)
  );

  for (genvar j = 0; j < `RBM_HIDDEN_DIM; j++) begin : g_hidden
    hidden_unit #(
      .UNIT_INDEX (j)
    ) u_hidden (
      .finish      (finish),
      .rst_n       (rst_n),
      .bcast       (bcast),
      .bcast_valid (bcast_valid),
      .ready       (unit_ready[j]),
      .prob        (probs[j]),
      .prob_valid  (probs_valid[j]),
      .take        (take)
    );
  end

  class_layer u_class (
    .finish      (finish),
    .rst_n       (rst_n),
    .probs       (probs),
    .probs_valid (probs_valid),
    .take        (take),
    .out_result  (out_result),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

endmodule

`default_nettype wire

/* tests/clock_gen.sv */
`default_nettype none

module clock_gen (
  output logic finish,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 10;

  // 10 ns period
  initial begin
    finish = 1'b0;
    forever #5 finish = ~finish;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge finish);
    @(negedge finish);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tests/rbm_tb.sv */
`default_nettype none

`include "rbm_macros.svh"

module rbm_tb import rbm_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_VEC = 10;
  localparam int LATENCY = 7;
  localparam int TIMEOUT_CYCLES = NUM_VEC * 40 + 10;

  logic          finish;
  logic          rst_n;
  feature_beat_t in_beat;
  logic          in_valid;
  logic          in_ready;
  rbm_result_t   out_result;
  logic          out_valid;
  logic          out_ready;

  // Features and out_ready stall length per vector
  logic signed [`RBM_DATA_W-1:0] feat_tab [NUM_VEC][`RBM_INPUT_DIM];
  int   stall_tab [NUM_VEC] = '{0, 0, 3, 30, 0, 0, 5, 0, 0, 0};
  int   exp_prob [NUM_VEC][`RBM_HIDDEN_DIM];
  int   exp_score [NUM_VEC][`RBM_OUTPUT_DIM];
  logic exp_class [NUM_VEC];
  int   last_cycle [NUM_VEC];
  int   cycle = 0;
  int   out_idx = 0;
  int   take_idx = 0;
  int   stall_left = 0;
  int   loaded_idx = -1;
  int   value_errors = 0;
  int   protocol_errors = 0;
  logic saw_backpressure = 1'b0;

  clock_gen u_clk (.finish(finish), .rst_n(rst_n));

  rbm_top dut (
    .finish     (finish),
    .rst_n      (rst_n),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_result (out_result),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

  function automatic int sigmoid(input int acc);
    int p;
    p = 128 + ((acc >>> 8) >>> 2);
    if (p < 0) return 0;
    if (p > 255) return 255;
    return p;
  endfunction

  task automatic compute_expected(input int v);
    int acc;
    int score;
    for (int j = 0; j < `RBM_HIDDEN_DIM; j++) begin
      acc = int'(hidden_bias(j));
      for (int i = 0; i < `RBM_INPUT_DIM; i++) begin
        acc += int'(feat_tab[v][i]) * int'(hidden_weight(i, j));
      end
      exp_prob[v][j] = sigmoid(acc);
    end
    for (int k = 0; k < `RBM_OUTPUT_DIM; k++) begin
      score = int'(class_bias(k));
      for (int j = 0; j < `RBM_HIDDEN_DIM; j++) begin
        score += exp_prob[v][j] * int'(class_weight(j, k));
      end
      exp_score[v][k] = score;
    end
    exp_class[v] = exp_score[v][1] > exp_score[v][0];
  endtask

  // Zero, saturating high, saturating low, ramp, then random
  task automatic fill_table();
    int f;
    for (int v = 0; v < NUM_VEC; v++) begin
      for (int i = 0; i < `RBM_INPUT_DIM; i++) begin
        case (v)
          0: f = 0;
          1: f = (hidden_weight(i, 0) < 0) ? -2048 : 2047;
          2: f = (hidden_weight(i, 0) < 0) ? 2047 : -2048;
          3: f = i * 137 - 1000;
          default: f = int'($urandom);
        endcase
        feat_tab[v][i] = `RBM_DATA_W'(f);
      end
    end
  endtask

  task automatic value_error(input string what, input int got, input int expected);
    value_errors++;
    $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, expected);
  endtask

  task automatic send_vector(input int v);
    for (int i = 0; i < `RBM_INPUT_DIM; i++) begin
      @(negedge finish);
      in_valid        = 1'b1;
      in_beat.feature = feat_tab[v][i];
      in_beat.last    = (i == `RBM_INPUT_DIM - 1);
      do @(posedge finish); while (!in_ready);
      if (in_beat.last) last_cycle[v] = cycle;
    end
  endtask

  task automatic print_counts();
    $display("Closing count: %0d value errors, %0d protocol errors",
             value_errors, protocol_errors);
  endtask

  always @(posedge finish) begin
    cycle <= cycle + 1;
  end

  // Sampled before the DUT registers update
  always @(posedge finish) begin
    if (rst_n) begin
      if (in_valid && !in_ready) saw_backpressure = 1'b1;
      if (dut.take && take_idx < NUM_VEC) begin
        for (int j = 0; j < `RBM_HIDDEN_DIM; j++) begin
          assert (int'(dut.probs[j]) == exp_prob[take_idx][j])
          else value_error($sformatf("prob %0d of vector %0d", j, take_idx),
                           int'(dut.probs[j]), exp_prob[take_idx][j]);
        end
        take_idx++;
      end
      if (out_valid) begin
        assert (out_idx < NUM_VEC) else begin
          protocol_errors++;
          $display("An extra result came out after the last vector");
        end
      end
      if (out_valid && out_idx < NUM_VEC) begin
        assert (int'(out_result.score0) == exp_score[out_idx][0])
        else value_error($sformatf("score0 of vector %0d", out_idx),
                         int'(out_result.score0), exp_score[out_idx][0]);
        assert (int'(out_result.score1) == exp_score[out_idx][1])
        else value_error($sformatf("score1 of vector %0d", out_idx),
                         int'(out_result.score1), exp_score[out_idx][1]);
        assert (out_result.class_id == exp_class[out_idx])
        else value_error($sformatf("class of vector %0d", out_idx),
                         int'(out_result.class_id), int'(exp_class[out_idx]));
        if (out_ready) begin
          if (out_idx == 0) begin
            assert (cycle - last_cycle[0] == LATENCY)
            else value_error("latency of the first result", cycle - last_cycle[0], LATENCY);
          end
          out_idx++;
        end
      end
    end
  end

  // out_ready stalls for the current result
  always @(negedge finish) begin
    if (rst_n) begin
      if (loaded_idx != out_idx && out_idx < NUM_VEC) begin
        stall_left = stall_tab[out_idx];
        loaded_idx = out_idx;
      end
      if (out_valid && stall_left > 0) begin
        out_ready = 1'b0;
        stall_left--;
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  initial begin
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b1;
    void'($urandom(86));
    fill_table();
    for (int v = 0; v < NUM_VEC; v++) compute_expected(v);
    wait (rst_n === 1'b1);
    @(negedge finish);
    assert (!out_valid && in_ready) else begin
      protocol_errors++;
      $display("After reset out_valid was not low or in_ready was not high");
    end
    for (int v = 0; v < NUM_VEC; v++) send_vector(v);
    @(negedge finish);
    in_valid = 1'b0;
    in_beat  = '0;
    wait (out_idx == NUM_VEC);
    repeat (3) @(negedge finish);
    assert (saw_backpressure) else begin
      protocol_errors++;
      $display("in_ready never fell while a result was held back");
    end
    print_counts();
    if (value_errors + protocol_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * 10);
    $display("Timeout after %0d cycles with %0d of %0d results received",
             TIMEOUT_CYCLES, out_idx, NUM_VEC);
    print_counts();
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+rtl
rtl/rbm_pkg.sv
rtl/feature_sequencer.sv
rtl/hidden_unit.sv
rtl/class_layer.sv
rtl/rbm_top.sv
tests/clock_gen.sv
tests/rbm_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f --top-module rbm_tb -o rbm_sim
./obj_dir/rbm_sim | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi
echo "Simulation passed"
